/* design/execPkg.sv */
`default_nettype none

package execPkg;

  localparam int defaultDataWidth = 32;
  localparam int regAddrWidth = 5;

  typedef enum logic [1:0]
  {
    opAdd      = 2'b00,
    opAddCarry = 2'b01,
    opSub      = 2'b10,
    opCompare  = 2'b11
  } addOpType;

  // bit 3 selects the signed form of the ordered conditions
  typedef enum logic [3:0]
  {
    cmpEqual         = 4'b0000,
    cmpNotEqual      = 4'b0001,
    cmpGreaterU      = 4'b0010,
    cmpGreaterEqualU = 4'b0011,
    cmpLessU         = 4'b0100,
    cmpLessEqualU    = 4'b0101,
    cmpGreaterS      = 4'b1010,
    cmpGreaterEqualS = 4'b1011,
    cmpLessS         = 4'b1100,
    cmpLessEqualS    = 4'b1101
  } compareCodeType;

  typedef enum logic [2:0]
  {
    logicAnd      = 3'b000,
    logicOr       = 3'b001,
    logicXor      = 3'b010,
    logicNor      = 3'b011,
    extByteSigned = 3'b100,
    extHalfSigned = 3'b101,
    extByteZero   = 3'b110,
    extHalfZero   = 3'b111
  } logicOpType;

  typedef enum logic [1:0]
  {
    shiftLeftLogical  = 2'b00,
    shiftRightLogical = 2'b01,
    shiftRightArith   = 2'b10,
    rotateRight       = 2'b11
  } shiftOpType;

  typedef enum logic [1:0]
  {
    selArith    = 2'b00,
    selLogic    = 2'b01,
    selShift    = 2'b10,
    selOperandB = 2'b11
  } resultSelType;

  // bit 2 marks sign extension, bits 1:0 give the access size
  typedef enum logic [2:0]
  {
    loadNone       = 3'b000,
    loadByteZero   = 3'b001,
    loadByteSigned = 3'b101,
    loadHalfZero   = 3'b010,
    loadHalfSigned = 3'b110,
    loadWord       = 3'b011
  } loadOpType;

  typedef enum logic [2:0]
  {
    storeNone = 3'b000,
    storeByte = 3'b001,
    storeHalf = 3'b010,
    storeWord = 3'b011
  } storeOpType;

endpackage

`default_nettype wire

/* design/arithUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module arithUnit
  #(parameter int dataWidth = execPkg::defaultDataWidth)
  (
    input wire [dataWidth-1:0]          operandA,
    input wire [dataWidth-1:0]          operandB,
    input wire execPkg::addOpType       addOp,
    input wire execPkg::compareCodeType compareControl,
    input wire                          carryIn,
    output logic [dataWidth-1:0]        arithResult,
    output logic                        arithCarry,
    output logic                        arithOverflow,
    output logic                        arithFlag
  );

  import execPkg::*;

  logic [dataWidth-1:0] addend;
  logic                 carrySelect;
  logic [dataWidth:0]   sum;
  logic                 isZero;
  logic                 lessUnsigned;
  logic                 lessSigned;
  logic                 compareResult;

  // subtract and compare both compute a + ~b + 1
  always_comb
  begin
    addend      = operandB;
    carrySelect = 1'b0;
    case (addOp)
      opAddCarry:
        carrySelect = carryIn;
      opSub,
      opCompare:
      begin
        addend      = ~operandB;
        carrySelect = 1'b1;
      end
      default:
        carrySelect = 1'b0;
    endcase
  end

  assign sum = {1'b0, operandA} + {1'b0, addend} + {{dataWidth{1'b0}}, carrySelect};

  assign arithResult = sum[dataWidth-1:0];
  // on a subtract the carry is the inverted borrow
  assign arithCarry = sum[dataWidth];
  assign arithOverflow = (operandA[dataWidth-1] == addend[dataWidth-1]) &&
                         (arithResult[dataWidth-1] != operandA[dataWidth-1]);

  assign isZero = (arithResult == '0);
  assign lessUnsigned = ~arithCarry;
  assign lessSigned = arithResult[dataWidth-1] ^ arithOverflow;

  always_comb
  begin
    case (compareControl)
      cmpEqual:         compareResult = isZero;
      cmpNotEqual:      compareResult = ~isZero;
      cmpGreaterU:      compareResult = ~lessUnsigned & ~isZero;
      cmpGreaterEqualU: compareResult = ~lessUnsigned;
      cmpLessU:         compareResult = lessUnsigned;
      cmpLessEqualU:    compareResult = lessUnsigned | isZero;
      cmpGreaterS:      compareResult = ~lessSigned & ~isZero;
      cmpGreaterEqualS: compareResult = ~lessSigned;
      cmpLessS:         compareResult = lessSigned;
      cmpLessEqualS:    compareResult = lessSigned | isZero;
      default:          compareResult = 1'b0;
    endcase
  end

  assign arithFlag = (addOp == opCompare) ? compareResult : isZero;

endmodule

`default_nettype wire

/* design/logicUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module logicUnit
  #(parameter int dataWidth = execPkg::defaultDataWidth)
  (
    input wire [dataWidth-1:0]      operandA,
    input wire [dataWidth-1:0]      operandB,
    input wire execPkg::logicOpType logicOp,
    output logic [dataWidth-1:0]    logicResult
  );

  import execPkg::*;

  logic [dataWidth-1:0] byteSigned;
  logic [dataWidth-1:0] halfSigned;
  logic [dataWidth-1:0] byteZero;
  logic [dataWidth-1:0] halfZero;

  // extensions work on the low part of operand A only
  assign byteSigned = {{(dataWidth-8){operandA[7]}}, operandA[7:0]};
  assign halfSigned = {{(dataWidth-16){operandA[15]}}, operandA[15:0]};
  assign byteZero = {{(dataWidth-8){1'b0}}, operandA[7:0]};
  assign halfZero = {{(dataWidth-16){1'b0}}, operandA[15:0]};

  always_comb
  begin
    case (logicOp)
      logicAnd:      logicResult = operandA & operandB;
      logicOr:       logicResult = operandA | operandB;
      logicXor:      logicResult = operandA ^ operandB;
      logicNor:      logicResult = ~(operandA | operandB);
      extByteSigned: logicResult = byteSigned;
      extHalfSigned: logicResult = halfSigned;
      extByteZero:   logicResult = byteZero;
      extHalfZero:   logicResult = halfZero;
      default:       logicResult = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/barrelShifter.sv */
`timescale 1ns/100ps
`default_nettype none

module barrelShifter
  #(parameter int dataWidth = execPkg::defaultDataWidth)
  (
    input wire [dataWidth-1:0]      operandA,
    input wire [dataWidth-1:0]      operandB,
    input wire execPkg::shiftOpType shiftOp,
    output logic [dataWidth-1:0]    shiftResult
  );

  import execPkg::*;

  localparam int amountWidth = $clog2(dataWidth);

  logic [amountWidth-1:0]   shiftAmount;
  logic [dataWidth-1:0]     leftLogical;
  logic [dataWidth-1:0]     rightLogical;
  logic [dataWidth-1:0]     rightArith;
  logic [2*dataWidth-1:0]   doubled;

  // only the low bits of operand B count (5 for a 32-bit word)
  assign shiftAmount = operandB[amountWidth-1:0];

  assign leftLogical = operandA << shiftAmount;
  assign rightLogical = operandA >> shiftAmount;
  assign rightArith = $signed(operandA) >>> shiftAmount;

  // rotate by shifting two copies side by side
  assign doubled = {operandA, operandA} >> shiftAmount;

  always_comb
  begin
    case (shiftOp)
      shiftLeftLogical:  shiftResult = leftLogical;
      shiftRightLogical: shiftResult = rightLogical;
      shiftRightArith:   shiftResult = rightArith;
      rotateRight:       shiftResult = doubled[dataWidth-1:0];
      default:           shiftResult = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/writebackStage.sv */
`timescale 1ns/100ps
`default_nettype none

module writebackStage
  #(parameter int dataWidth = execPkg::defaultDataWidth)
  (
    input wire                               clock,
    input wire                               arstN,
    input wire                               stall,
    input wire                               flush,
    input wire [dataWidth-1:0]               arithResult,
    input wire [dataWidth-1:0]               logicResult,
    input wire [dataWidth-1:0]               shiftResult,
    input wire [dataWidth-1:0]               operandB,
    input wire execPkg::resultSelType        resultSelection,
    input wire [execPkg::regAddrWidth-1:0]   destination,
    input wire                               weDestination,
    input wire                               arithCarry,
    input wire                               arithOverflow,
    input wire                               arithFlag,
    input wire                               updateCarry,
    input wire                               updateOverflow,
    input wire                               updateFlag,
    output logic [dataWidth-1:0]             writeData,
    output logic [execPkg::regAddrWidth-1:0] writeAddress,
    output logic                             writeEnable,
    output logic                             carryOut,
    output logic                             weCarry,
    output logic                             overflowOut,
    output logic                             weOverflow,
    output logic                             flagOut,
    output logic                             weFlag
  );

  import execPkg::*;

  logic [dataWidth-1:0] selectedResult;

  always_comb
  begin
    case (resultSelection)
      selArith:    selectedResult = arithResult;
      selLogic:    selectedResult = logicResult;
      selShift:    selectedResult = shiftResult;
      selOperandB: selectedResult = operandB;
      default:     selectedResult = operandB;
    endcase
  end

  // a flush turns the instruction into a bubble by clearing its write enables
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      writeEnable <= 1'b0;
      weCarry     <= 1'b0;
      weOverflow  <= 1'b0;
      weFlag      <= 1'b0;
    end
    else if (!stall)
    begin
      writeEnable <= weDestination & ~flush;
      weCarry     <= updateCarry & ~flush;
      weOverflow  <= updateOverflow & ~flush;
      weFlag      <= updateFlag & ~flush;
    end
  end

  // result and status values follow every unstalled cycle
  always_ff @(posedge clock)
  begin
    if (!stall)
    begin
      writeData    <= selectedResult;
      writeAddress <= destination;
      carryOut     <= arithCarry;
      overflowOut  <= arithOverflow;
      flagOut      <= arithFlag;
    end
  end

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/100ps
`default_nettype none

module memoryStage
  #(parameter int dataWidth = execPkg::defaultDataWidth)
  (
    input wire                       clock,
    input wire                       arstN,
    input wire                       stall,
    input wire                       flush,
    input wire [dataWidth-1:0]       arithResult,
    input wire [dataWidth-1:0]       storeDataIn,
    input wire execPkg::loadOpType   load,
    input wire execPkg::storeOpType  store,
    output logic [dataWidth-1:0]     memoryAddress,
    output execPkg::loadOpType       memoryLoad,
    output execPkg::storeOpType      memoryStore,
    output logic [dataWidth-1:0]     dataOut,
    output logic                     alignmentError
  );

  import execPkg::*;

  loadOpType  loadReg;
  storeOpType storeReg;
  logic       memoryAccess;
  logic       wordAccess;
  logic       halfAccess;

  assign memoryAccess = (load != loadNone) || (store != storeNone);

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      loadReg  <= loadNone;
      storeReg <= storeNone;
    end
    else if (!stall)
    begin
      loadReg  <= flush ? loadNone : load;
      storeReg <= flush ? storeNone : store;
    end
  end

  // address and store data keep their value between memory instructions
  always_ff @(posedge clock)
  begin
    if (!stall && memoryAccess)
    begin
      memoryAddress <= arithResult;
    end
    if (!stall && store != storeNone)
    begin
      dataOut <= storeDataIn;
    end
  end

  assign wordAccess = (loadReg == loadWord) || (storeReg == storeWord);
  assign halfAccess = (loadReg == loadHalfZero) || (loadReg == loadHalfSigned) ||
                      (storeReg == storeHalf);

  // a misaligned access never reaches the data cache
  assign alignmentError = (wordAccess && memoryAddress[1:0] != 2'b00) ||
                          (halfAccess && memoryAddress[0]);

  assign memoryLoad = alignmentError ? loadNone : loadReg;
  assign memoryStore = alignmentError ? storeNone : storeReg;

endmodule

`default_nettype wire

/* design/executeUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module executeUnit
  #(parameter int dataWidth = execPkg::defaultDataWidth)
  (
    input wire                               clock,
    input wire                               arstN,
    input wire                               stall,
    input wire                               flush,
    input wire [dataWidth-1:0]               operandA,
    input wire [dataWidth-1:0]               operandB,
    input wire [dataWidth-1:0]               storeDataIn,
    input wire [execPkg::regAddrWidth-1:0]   destination,
    input wire                               weDestination,
    input wire [2:0]                         exeControl,
    input wire execPkg::compareCodeType      compareControl,
    input wire execPkg::resultSelType        resultSelection,
    input wire                               carryIn,
    input wire                               updateCarry,
    input wire                               updateOverflow,
    input wire                               updateFlag,
    input wire execPkg::loadOpType           load,
    input wire execPkg::storeOpType          store,
    output logic [dataWidth-1:0]             writeData,
    output logic [execPkg::regAddrWidth-1:0] writeAddress,
    output logic                             writeEnable,
    output logic                             carryOut,
    output logic                             weCarry,
    output logic                             overflowOut,
    output logic                             weOverflow,
    output logic                             flagOut,
    output logic                             weFlag,
    output logic [dataWidth-1:0]             memoryAddress,
    output execPkg::loadOpType               memoryLoad,
    output execPkg::storeOpType              memoryStore,
    output logic [dataWidth-1:0]             dataOut,
    output logic                             alignmentError
  );

  import execPkg::*;

  logic [dataWidth-1:0] arithResult;
  logic                 arithCarry;
  logic                 arithOverflow;
  logic                 arithFlag;
  logic [dataWidth-1:0] logicResult;
  logic [dataWidth-1:0] shiftResult;

  // the adder and shifter only look at the low two control bits
  arithUnit #(.dataWidth(dataWidth)) arith0
  (
    .operandA(operandA),
    .operandB(operandB),
    .addOp(addOpType'(exeControl[1:0])),
    .compareControl(compareControl),
    .carryIn(carryIn),
    .arithResult(arithResult),
    .arithCarry(arithCarry),
    .arithOverflow(arithOverflow),
    .arithFlag(arithFlag)
  );

  logicUnit #(.dataWidth(dataWidth)) logic0
  (
    .operandA(operandA),
    .operandB(operandB),
    .logicOp(logicOpType'(exeControl)),
    .logicResult(logicResult)
  );

  barrelShifter #(.dataWidth(dataWidth)) shifter0
  (
    .operandA(operandA),
    .operandB(operandB),
    .shiftOp(shiftOpType'(exeControl[1:0])),
    .shiftResult(shiftResult)
  );

  writebackStage #(.dataWidth(dataWidth)) writeback0
  (
    .clock(clock),
    .arstN(arstN),
    .stall(stall),
    .flush(flush),
    .arithResult(arithResult),
    .logicResult(logicResult),
    .shiftResult(shiftResult),
    .operandB(operandB),
    .resultSelection(resultSelection),
    .destination(destination),
    .weDestination(weDestination),
    .arithCarry(arithCarry),
    .arithOverflow(arithOverflow),
    .arithFlag(arithFlag),
    .updateCarry(updateCarry),
    .updateOverflow(updateOverflow),
    .updateFlag(updateFlag),
    .writeData(writeData),
    .writeAddress(writeAddress),
    .writeEnable(writeEnable),
    .carryOut(carryOut),
    .weCarry(weCarry),
    .overflowOut(overflowOut),
    .weOverflow(weOverflow),
    .flagOut(flagOut),
    .weFlag(weFlag)
  );

  // effective address is base plus offset from the adder
  memoryStage #(.dataWidth(dataWidth)) memory0
  (
    .clock(clock),
    .arstN(arstN),
    .stall(stall),
    .flush(flush),
    .arithResult(arithResult),
    .storeDataIn(storeDataIn),
    .load(load),
    .store(store),
    .memoryAddress(memoryAddress),
    .memoryLoad(memoryLoad),
    .memoryStore(memoryStore),
    .dataOut(dataOut),
    .alignmentError(alignmentError)
  );

endmodule

`default_nettype wire

/* sim/tbVectors.svh */
`ifndef tbVectorsSvh
`define tbVectorsSvh

// one row per instruction with the outputs expected one cycle later
// controlBits hold stall, flush, weDestination, carryIn, updateCarry, updateOverflow, updateFlag
// statusBits hold writeEnable, carryOut, weCarry, overflowOut, weOverflow, flagOut, weFlag
// and alignmentError
typedef struct packed
{
  logic [6:0]                  controlBits;
  logic [2:0]                  exeControl;
  compareCodeType              compareControl;
  resultSelType                resultSelection;
  logic [regAddrWidth-1:0]     destination;
  loadOpType                   load;
  storeOpType                  store;
  logic [defaultDataWidth-1:0] operandA;
  logic [defaultDataWidth-1:0] operandB;
  logic [defaultDataWidth-1:0] storeDataIn;
  logic [defaultDataWidth-1:0] writeData;
  logic [regAddrWidth-1:0]     writeAddress;
  logic [7:0]                  statusBits;
  logic [defaultDataWidth-1:0] memoryAddress;
  loadOpType                   memoryLoad;
  storeOpType                  memoryStore;
  logic [defaultDataWidth-1:0] dataOut;
} vectorType;

localparam int numVectors = 31;

localparam vectorType vectors [numVectors] =
'{
  // memory accesses first so address and store data are known
  '{7'b0000000, 3'b000, cmpEqual, selArith, 5'd0, loadNone, storeWord,
    32'h00001000, 32'h00000010, 32'hcafef00d, 32'h00001010, 5'd0,
    8'b00000000, 32'h00001010, loadNone, storeWord, 32'hcafef00d},
  '{7'b0010000, 3'b000, cmpEqual, selArith, 5'd23, loadByteZero, storeNone,
    32'h00002000, 32'h00000003, 32'h00000000, 32'h00002003, 5'd23,
    8'b10000000, 32'h00002003, loadByteZero, storeNone, 32'hcafef00d},
  '{7'b0000000, 3'b000, cmpEqual, selArith, 5'd0, loadNone, storeHalf,
    32'h00003000, 32'h00000002, 32'h0000beef, 32'h00003002, 5'd0,
    8'b00000000, 32'h00003002, loadNone, storeHalf, 32'h0000beef},
  '{7'b0010000, 3'b000, cmpEqual, selArith, 5'd24, loadWord, storeNone,
    32'h00004000, 32'h00000004, 32'h00000000, 32'h00004004, 5'd24,
    8'b10000000, 32'h00004004, loadWord, storeNone, 32'h0000beef},
  // misaligned half load and word store
  '{7'b0010000, 3'b000, cmpEqual, selArith, 5'd25, loadHalfSigned, storeNone,
    32'h00005000, 32'h00000001, 32'h00000000, 32'h00005001, 5'd25,
    8'b10000001, 32'h00005001, loadNone, storeNone, 32'h0000beef},
  '{7'b0000000, 3'b000, cmpEqual, selArith, 5'd0, loadNone, storeWord,
    32'h00006000, 32'h00000002, 32'h11112222, 32'h00006002, 5'd0,
    8'b00000001, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // add, wraparound, add with carry
  '{7'b0010111, 3'b000, cmpEqual, selArith, 5'd1, loadNone, storeNone,
    32'h00000005, 32'h00000003, 32'h00000000, 32'h00000008, 5'd1,
    8'b10101010, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010111, 3'b000, cmpEqual, selArith, 5'd2, loadNone, storeNone,
    32'hffffffff, 32'h00000001, 32'h00000000, 32'h00000000, 5'd2,
    8'b11101110, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0011111, 3'b001, cmpEqual, selArith, 5'd3, loadNone, storeNone,
    32'h00000010, 32'h00000020, 32'h00000000, 32'h00000031, 5'd3,
    8'b10101010, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // subtract ignores carryIn
  '{7'b0011111, 3'b010, cmpEqual, selArith, 5'd4, loadNone, storeNone,
    32'h00000005, 32'h00000007, 32'h00000000, 32'hfffffffe, 5'd4,
    8'b10101010, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010111, 3'b010, cmpEqual, selArith, 5'd5, loadNone, storeNone,
    32'h80000000, 32'h00000001, 32'h00000000, 32'h7fffffff, 5'd5,
    8'b11111010, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // -1 against 1 where signed and unsigned orders differ
  '{7'b0000001, 3'b011, cmpLessU, selArith, 5'd6, loadNone, storeNone,
    32'hffffffff, 32'h00000001, 32'h00000000, 32'hfffffffe, 5'd6,
    8'b01000010, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0000001, 3'b011, cmpLessS, selArith, 5'd7, loadNone, storeNone,
    32'hffffffff, 32'h00000001, 32'h00000000, 32'hfffffffe, 5'd7,
    8'b01000110, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0000001, 3'b011, cmpGreaterU, selArith, 5'd8, loadNone, storeNone,
    32'hffffffff, 32'h00000001, 32'h00000000, 32'hfffffffe, 5'd8,
    8'b01000110, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0000001, 3'b011, cmpGreaterS, selArith, 5'd9, loadNone, storeNone,
    32'hffffffff, 32'h00000001, 32'h00000000, 32'hfffffffe, 5'd9,
    8'b01000010, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // carryOut in the logic rows still follows the adder mode in the low bits
  '{7'b0010000, 3'b000, cmpEqual, selLogic, 5'd10, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'h02040086, 5'd10,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b001, cmpEqual, selLogic, 5'd11, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'h1f3f80ff, 5'd11,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b010, cmpEqual, selLogic, 5'd12, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'h1d3b8079, 5'd12,
    8'b11000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b011, cmpEqual, selLogic, 5'd13, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'he0c07f00, 5'd13,
    8'b11000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b100, cmpEqual, selLogic, 5'd14, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'hffffff86, 5'd14,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b101, cmpEqual, selLogic, 5'd15, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'hffff8086, 5'd15,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b110, cmpEqual, selLogic, 5'd16, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'h00000086, 5'd16,
    8'b11000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b111, cmpEqual, selLogic, 5'd17, loadNone, storeNone,
    32'h12348086, 32'h0f0f00ff, 32'h00000000, 32'h00008086, 5'd17,
    8'b11000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // shift amount 0x24 uses only its low five bits
  '{7'b0010000, 3'b000, cmpEqual, selShift, 5'd18, loadNone, storeNone,
    32'h800000f1, 32'h00000024, 32'h00000000, 32'h00000f10, 5'd18,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b001, cmpEqual, selShift, 5'd19, loadNone, storeNone,
    32'h800000f1, 32'h00000024, 32'h00000000, 32'h0800000f, 5'd19,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b010, cmpEqual, selShift, 5'd20, loadNone, storeNone,
    32'h800000f1, 32'h00000024, 32'h00000000, 32'hf800000f, 5'd20,
    8'b11000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b011, cmpEqual, selShift, 5'd21, loadNone, storeNone,
    32'h800000f1, 32'h00000024, 32'h00000000, 32'h1800000f, 5'd21,
    8'b11000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  '{7'b0010000, 3'b000, cmpEqual, selOperandB, 5'd22, loadNone, storeNone,
    32'h00000000, 32'hdeadbeef, 32'h00000000, 32'hdeadbeef, 5'd22,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // stalled row repeats the outputs of the row before
  '{7'b1010111, 3'b000, cmpEqual, selArith, 5'd30, loadNone, storeWord,
    32'h00000001, 32'h00000001, 32'h99999999, 32'hdeadbeef, 5'd22,
    8'b10000000, 32'h00006002, loadNone, storeNone, 32'h11112222},
  // flushed store still moves address, data and writeData
  '{7'b0110111, 3'b000, cmpEqual, selArith, 5'd31, loadNone, storeWord,
    32'h00000100, 32'h00000004, 32'h77777777, 32'h00000104, 5'd31,
    8'b00000000, 32'h00000104, loadNone, storeNone, 32'h77777777},
  '{7'b0010111, 3'b000, cmpEqual, selArith, 5'd1, loadWord, storeNone,
    32'h00000008, 32'h00000008, 32'h00000000, 32'h00000010, 5'd1,
    8'b10101010, 32'h00000010, loadWord, storeNone, 32'h77777777}
};

`endif

/* sim/tbExecuteUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module tbExecuteUnit;

  import execPkg::*;

  localparam int dataWidth = defaultDataWidth;
  localparam int resetCycles = 4;

  logic                    clock;
  logic                    arstN;
  logic                    stall;
  logic                    flush;
  logic [dataWidth-1:0]    operandA;
  logic [dataWidth-1:0]    operandB;
  logic [dataWidth-1:0]    storeDataIn;
  logic [regAddrWidth-1:0] destination;
  logic                    weDestination;
  logic [2:0]              exeControl;
  compareCodeType          compareControl;
  resultSelType            resultSelection;
  logic                    carryIn;
  logic                    updateCarry;
  logic                    updateOverflow;
  logic                    updateFlag;
  loadOpType               load;
  storeOpType              store;
  logic [dataWidth-1:0]    writeData;
  logic [regAddrWidth-1:0] writeAddress;
  logic                    writeEnable;
  logic                    carryOut;
  logic                    weCarry;
  logic                    overflowOut;
  logic                    weOverflow;
  logic                    flagOut;
  logic                    weFlag;
  logic [dataWidth-1:0]    memoryAddress;
  loadOpType               memoryLoad;
  storeOpType              memoryStore;
  logic [dataWidth-1:0]    dataOut;
  logic                    alignmentError;

  `include "tbVectors.svh"

  // table rows plus reset plus some slack
  localparam int cycleLimit = numVectors + resetCycles + 10;

  int cycleCount = 0;

  executeUnit #(.dataWidth(dataWidth)) dut0
  (
    .clock(clock),
    .arstN(arstN),
    .stall(stall),
    .flush(flush),
    .operandA(operandA),
    .operandB(operandB),
    .storeDataIn(storeDataIn),
    .destination(destination),
    .weDestination(weDestination),
    .exeControl(exeControl),
    .compareControl(compareControl),
    .resultSelection(resultSelection),
    .carryIn(carryIn),
    .updateCarry(updateCarry),
    .updateOverflow(updateOverflow),
    .updateFlag(updateFlag),
    .load(load),
    .store(store),
    .writeData(writeData),
    .writeAddress(writeAddress),
    .writeEnable(writeEnable),
    .carryOut(carryOut),
    .weCarry(weCarry),
    .overflowOut(overflowOut),
    .weOverflow(weOverflow),
    .flagOut(flagOut),
    .weFlag(weFlag),
    .memoryAddress(memoryAddress),
    .memoryLoad(memoryLoad),
    .memoryStore(memoryStore),
    .dataOut(dataOut),
    .alignmentError(alignmentError)
  );

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout, the vector table did not finish within %0d cycles", cycleLimit);
      $display("*** FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic failRun();
    $display("*** FAILED ***");
    $fatal(1, "output mismatch");
  endtask

  task automatic checkWord(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      failRun();
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
      failRun();
    end
  endtask

  task automatic checkLoad(input string name, input loadOpType expected,
                           input loadOpType actual);
    if (actual !== expected)
    begin
      $display("ERR %0t %s expected %s(%b) actual %s(%b)", $time, name,
               expected.name(), expected, actual.name(), actual);
      failRun();
    end
  endtask

  task automatic checkStore(input string name, input storeOpType expected,
                            input storeOpType actual);
    if (actual !== expected)
    begin
      $display("ERR %0t %s expected %s(%b) actual %s(%b)", $time, name,
               expected.name(), expected, actual.name(), actual);
      failRun();
    end
  endtask

  task automatic driveIdle();
    stall           <= 1'b0;
    flush           <= 1'b0;
    operandA        <= '0;
    operandB        <= '0;
    storeDataIn     <= '0;
    destination     <= '0;
    weDestination   <= 1'b0;
    exeControl      <= 3'b000;
    compareControl  <= cmpEqual;
    resultSelection <= selArith;
    carryIn         <= 1'b0;
    updateCarry     <= 1'b0;
    updateOverflow  <= 1'b0;
    updateFlag      <= 1'b0;
    load            <= loadNone;
    store           <= storeNone;
  endtask

  task automatic driveRow(input vectorType row);
    stall           <= row.controlBits[6];
    flush           <= row.controlBits[5];
    weDestination   <= row.controlBits[4];
    carryIn         <= row.controlBits[3];
    updateCarry     <= row.controlBits[2];
    updateOverflow  <= row.controlBits[1];
    updateFlag      <= row.controlBits[0];
    operandA        <= row.operandA;
    operandB        <= row.operandB;
    storeDataIn     <= row.storeDataIn;
    destination     <= row.destination;
    exeControl      <= row.exeControl;
    compareControl  <= row.compareControl;
    resultSelection <= row.resultSelection;
    load            <= row.load;
    store           <= row.store;
  endtask

  // enables and access codes that reset and flush clear
  task automatic checkCleared();
    checkBit("writeEnable", 1'b0, writeEnable);
    checkBit("weCarry", 1'b0, weCarry);
    checkBit("weOverflow", 1'b0, weOverflow);
    checkBit("weFlag", 1'b0, weFlag);
    checkLoad("memoryLoad", loadNone, memoryLoad);
    checkStore("memoryStore", storeNone, memoryStore);
    checkBit("alignmentError", 1'b0, alignmentError);
  endtask

  task automatic checkOutputs(input vectorType row);
    checkWord("writeData", row.writeData, writeData);
    checkWord("writeAddress", dataWidth'(row.writeAddress), dataWidth'(writeAddress));
    checkBit("writeEnable", row.statusBits[7], writeEnable);
    checkBit("carryOut", row.statusBits[6], carryOut);
    checkBit("weCarry", row.statusBits[5], weCarry);
    checkBit("overflowOut", row.statusBits[4], overflowOut);
    checkBit("weOverflow", row.statusBits[3], weOverflow);
    checkBit("flagOut", row.statusBits[2], flagOut);
    checkBit("weFlag", row.statusBits[1], weFlag);
    checkBit("alignmentError", row.statusBits[0], alignmentError);
    checkWord("memoryAddress", row.memoryAddress, memoryAddress);
    checkLoad("memoryLoad", row.memoryLoad, memoryLoad);
    checkStore("memoryStore", row.memoryStore, memoryStore);
    checkWord("dataOut", row.dataOut, dataOut);
  endtask

  initial
  begin
    int rowIndex;
    arstN <= 1'b0;
    driveIdle();
    repeat (resetCycles - 1) @(posedge clock);
    @(negedge clock);
    checkCleared();
    @(posedge clock);
    arstN <= 1'b1;
    // first cycle out of reset
    @(posedge clock);
    @(negedge clock);
    checkCleared();
    // each row is checked on the cycle after the next one is driven
    for (rowIndex = 0; rowIndex < numVectors; rowIndex++)
    begin
      @(posedge clock);
      driveRow(vectors[rowIndex]);
      if (rowIndex > 0)
      begin
        @(negedge clock);
        checkOutputs(vectors[rowIndex - 1]);
      end
    end
    @(posedge clock);
    driveIdle();
    @(negedge clock);
    checkOutputs(vectors[numVectors - 1]);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
design/execPkg.sv
design/arithUnit.sv
design/logicUnit.sv
design/barrelShifter.sv
design/writebackStage.sv
design/memoryStage.sv
design/executeUnit.sv
sim/tbExecuteUnit.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it, the exit status carries the result
verilator --binary -f project.f --top-module tbExecuteUnit -o simExecuteUnit &&
  ./obj_dir/simExecuteUnit ||
  { echo "simulation did not pass"; exit 1; }
